// ==== logic/exec_consts.svh ====
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// Operand and result width of both lanes
`define DATA_WIDTH 32
`define REG_ADDR_WIDTH 5

// One multiplier bit is retired per step
`define MUL_CYCLES 32

`endif

// ==== logic/exec_pkg.sv ====
`include "exec_consts.svh"

package exec_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operations and control states
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSlt, // Signed compare, result is 1 or 0
        opSll, // Shift amount is the low 5 bits of B
        opMul  // Low half of the product, master lane only
    } aluOpE;

    typedef enum logic [1:0] {
        stIdle,
        stExec,
        stSplit, // Master result pending, slave waits for forwarding
        stMul
    } issueStateE;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Lane payloads
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic                        valid;
        aluOpE                       op;
        logic [`REG_ADDR_WIDTH-1:0]  srcA;
        logic [`REG_ADDR_WIDTH-1:0]  srcB;
        logic [`REG_ADDR_WIDTH-1:0]  dest;
        logic                        writes;
        logic [`DATA_WIDTH-1:0]      aValue;
        logic [`DATA_WIDTH-1:0]      bValue; // Immediate already merged by decode
    } slotT;

    typedef struct packed {
        logic                        valid;
        logic [`REG_ADDR_WIDTH-1:0]  dest;
        logic [`DATA_WIDTH-1:0]      value;
    } resultT;

endpackage

// ==== logic/laneBus_if.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

interface laneBus_if;
    import exec_pkg::*;

    slotT                    slot;   // Instruction held in the lane
    logic                    loaded; // Lane holds a live instruction
    logic [`DATA_WIDTH-1:0]  value;  // Lane result

    // Register side owns the held instruction
    modport regSide (
        output slot,
        output loaded
    );

    // Execution side turns it into a value
    modport aluSide (
        input  slot,
        input  loaded,
        output value
    );

endinterface

// ==== logic/issueRegister.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module issueRegister (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    masterEn,
    input  logic                    slaveEn,
    input  logic                    masterFlush,
    input  logic                    slaveFlush,
    input  logic                    fwdA,
    input  logic                    fwdB,
    input  exec_pkg::slotT          masterSlot,
    input  exec_pkg::slotT          slaveSlot,
    input  logic [`DATA_WIDTH-1:0]  fwdValue,
    laneBus_if.regSide              masterBus,
    laneBus_if.regSide              slaveBus
);
    import exec_pkg::*;

    slotT masterHeld;
    slotT slaveHeld;
    slotT slaveNext;
    logic slaveLoaded;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Master lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            masterHeld <= '0;
        end else if (masterFlush) begin
            masterHeld <= '0;
        end else if (masterEn) begin
            masterHeld <= masterSlot;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Slave lane
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // A reissue after a split comes from the lane's own copy
    always_comb begin
        slaveNext = (fwdA || fwdB) ? slaveHeld : slaveSlot;
        if (fwdA) begin
            slaveNext.aValue = fwdValue;
        end
        if (fwdB) begin
            slaveNext.bValue = fwdValue;
        end
    end

    always_ff @(posedge clk) begin
        if (slaveEn) begin
            slaveHeld <= slaveNext; // Kept even when flushed, for the split case
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            slaveLoaded <= 1'b0;
        end else if (slaveFlush) begin
            slaveLoaded <= 1'b0;
        end else if (slaveEn) begin
            slaveLoaded <= 1'b1;
        end
    end

    assign masterBus.slot   = masterHeld;
    assign masterBus.loaded = masterHeld.valid;
    assign slaveBus.slot    = slaveHeld;
    assign slaveBus.loaded  = slaveLoaded;

endmodule

// ==== logic/issueControl.sv ====
`timescale 1ns/1ps

module issueControl (
    input  logic            clk,
    input  logic            rstN,
    input  logic            inValid,
    input  logic            outReady,
    input  exec_pkg::slotT  masterSlot,
    input  exec_pkg::slotT  slaveSlot,
    input  logic            mulLast,
    output logic            inReady,
    output logic            outValid,
    output logic            masterEn,
    output logic            slaveEn,
    output logic            masterFlush,
    output logic            slaveFlush,
    output logic            fwdA,
    output logic            fwdB,
    output logic            mulStart
);
    import exec_pkg::*;

    issueStateE state;
    issueStateE nextState;
    issueStateE issueTarget;
    logic       armed;
    logic       holdFwdA;
    logic       holdFwdB;
    logic       accept;
    logic       transfer;
    logic       matchA;
    logic       matchB;
    logic       isMul;

    // Slave reads what the master is about to write
    assign matchA = slaveSlot.valid && masterSlot.writes && (masterSlot.dest != '0)
                    && (masterSlot.dest == slaveSlot.srcA);
    assign matchB = slaveSlot.valid && masterSlot.writes && (masterSlot.dest != '0)
                    && (masterSlot.dest == slaveSlot.srcB);
    assign isMul  = masterSlot.valid && (masterSlot.op == opMul);

    assign inReady  = ((state == stIdle) && armed) || ((state == stExec) && outReady);
    assign outValid = (state == stExec) || (state == stSplit);
    assign accept   = inValid && inReady;
    assign transfer = outValid && outReady;

    assign issueTarget = isMul ? stMul : ((matchA || matchB) ? stSplit : stExec);

    always_comb begin
        nextState = state;
        case (state)
            stIdle:  if (accept) nextState = issueTarget;
            stExec:  if (transfer) nextState = accept ? issueTarget : stIdle;
            stSplit: if (transfer) nextState = stExec; // Slave reissues at this edge
            stMul:   if (mulLast) nextState = (holdFwdA || holdFwdB) ? stSplit : stExec;
            default: nextState = stIdle;
        endcase
    end

    assign masterEn    = accept;
    assign slaveEn     = accept || ((state == stSplit) && transfer);
    assign masterFlush = !accept && ((state == stIdle) || transfer);
    assign slaveFlush  = accept ? (matchA || matchB)
                                : ((state == stIdle) || ((state == stExec) && transfer));
    assign fwdA        = (state == stSplit) && transfer && holdFwdA;
    assign fwdB        = (state == stSplit) && transfer && holdFwdB;
    assign mulStart    = accept && isMul;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= stIdle;
            armed    <= 1'b0;
            holdFwdA <= 1'b0;
            holdFwdB <= 1'b0;
        end else begin
            state <= nextState;
            armed <= 1'b1; // Input opens one cycle after reset
            if (accept) begin
                holdFwdA <= matchA;
                holdFwdB <= matchB;
            end
        end
    end

endmodule

// ==== logic/mulCycleCounter.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module mulCycleCounter (
    input  logic clk,
    input  logic rstN,
    input  logic mulStart,
    output logic mulStep,
    output logic mulLast
);

    localparam int CountWidth = $clog2(`MUL_CYCLES + 1);

    logic [CountWidth-1:0] count;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (mulStart) begin
            count <= CountWidth'(`MUL_CYCLES);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

    assign mulStep = (count != '0);
    assign mulLast = (count == CountWidth'(1)); // Final multiplier bit

endmodule

// ==== logic/laneAlu.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module laneAlu (
    input  logic        clk,
    input  logic        rstN,
    input  logic        mulStep,
    laneBus_if.aluSide  bus
);
    import exec_pkg::*;

    logic [`DATA_WIDTH-1:0] a;
    logic [`DATA_WIDTH-1:0] b;
    logic [`DATA_WIDTH-1:0] acc;
    logic [`DATA_WIDTH-1:0] mcand;
    logic [`DATA_WIDTH-1:0] mplier;
    logic [`DATA_WIDTH-1:0] curAcc;
    logic [`DATA_WIDTH-1:0] curMcand;
    logic [`DATA_WIDTH-1:0] curMplier;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic                   running;

    assign a = bus.slot.aValue;
    assign b = bus.slot.bValue;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Shift-add multiplier
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // First step starts straight from the lane operands
    assign curAcc    = running ? acc : '0;
    assign curMcand  = running ? mcand : a;
    assign curMplier = running ? mplier : b;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            running <= 1'b0;
        end else begin
            running <= mulStep;
        end
    end

    always_ff @(posedge clk) begin
        if (mulStep) begin
            acc    <= curAcc + (curMplier[0] ? curMcand : '0);
            mcand  <= curMcand << 1;
            mplier <= curMplier >> 1;
        end
    end

    always_comb begin
        case (bus.slot.op)
            opAdd:   aluOut = a + b;
            opSub:   aluOut = a - b;
            opAnd:   aluOut = a & b;
            opOr:    aluOut = a | b;
            opXor:   aluOut = a ^ b;
            opSlt:   aluOut = {{(`DATA_WIDTH-1){1'b0}}, ($signed(a) < $signed(b))};
            opSll:   aluOut = a << b[4:0];
            opMul:   aluOut = acc; // Holds after the last step
            default: aluOut = '0;
        endcase
    end

    assign bus.value = bus.loaded ? aluOut : '0; // Empty lane reads as zero

endmodule

// ==== logic/dualIssueExec.sv ====
`timescale 1ns/1ps

module dualIssueExec (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  exec_pkg::slotT    masterSlot,
    input  exec_pkg::slotT    slaveSlot,
    input  logic              outReady,
    output logic              inReady,
    output logic              outValid,
    output exec_pkg::resultT  masterResult,
    output exec_pkg::resultT  slaveResult
);

    logic masterEn;
    logic slaveEn;
    logic masterFlush;
    logic slaveFlush;
    logic fwdA;
    logic fwdB;
    logic mulStart;
    logic mulStep;
    logic mulLast;

    laneBus_if masterBus ();
    laneBus_if slaveBus ();

    issueControl issueControl_inst (
        .clk         (clk),
        .rstN        (rstN),
        .inValid     (inValid),
        .outReady    (outReady),
        .masterSlot  (masterSlot),
        .slaveSlot   (slaveSlot),
        .mulLast     (mulLast),
        .inReady     (inReady),
        .outValid    (outValid),
        .masterEn    (masterEn),
        .slaveEn     (slaveEn),
        .masterFlush (masterFlush),
        .slaveFlush  (slaveFlush),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .mulStart    (mulStart)
    );

    // Master result feeds the split slave's stale operands
    issueRegister issueRegister_inst (
        .clk         (clk),
        .rstN        (rstN),
        .masterEn    (masterEn),
        .slaveEn     (slaveEn),
        .masterFlush (masterFlush),
        .slaveFlush  (slaveFlush),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .masterSlot  (masterSlot),
        .slaveSlot   (slaveSlot),
        .fwdValue    (masterBus.value),
        .masterBus   (masterBus.regSide),
        .slaveBus    (slaveBus.regSide)
    );

    mulCycleCounter mulCycleCounter_inst (
        .clk      (clk),
        .rstN     (rstN),
        .mulStart (mulStart),
        .mulStep  (mulStep),
        .mulLast  (mulLast)
    );

    laneAlu masterAlu_inst (
        .clk     (clk),
        .rstN    (rstN),
        .mulStep (mulStep),
        .bus     (masterBus.aluSide)
    );

    laneAlu slaveAlu_inst (
        .clk     (clk),
        .rstN    (rstN),
        .mulStep (1'b0), // No multiplier in the slave slot
        .bus     (slaveBus.aluSide)
    );

    assign masterResult.valid = masterBus.loaded && masterBus.slot.valid;
    assign masterResult.dest  = masterBus.slot.dest;
    assign masterResult.value = masterBus.value;

    assign slaveResult.valid = slaveBus.loaded && slaveBus.slot.valid;
    assign slaveResult.dest  = slaveBus.slot.dest;
    assign slaveResult.value = slaveBus.value;

endmodule

// ==== dv/dualIssueExec_checker.sv ====
`timescale 1ns/1ps

module dualIssueExec_checker (
    input  logic              clk,
    input  logic              rstN,
    input  logic              inValid,
    input  logic              inReady,
    input  logic              outValid,
    input  logic              outReady,
    input  exec_pkg::slotT    slaveSlot,
    input  exec_pkg::resultT  masterResult,
    input  exec_pkg::resultT  slaveResult
);
    import exec_pkg::*;

    int unsigned failCount = 0;

    // Both handshakes stay closed in the first cycle out of reset
    resetQuiet: assert property (@(posedge clk) $rose(rstN) |-> (!inReady && !outValid))
        else begin
            $error("Handshake open in the first cycle after reset");
            failCount++;
        end

    resultsHeld: assert property (@(posedge clk) disable iff (!rstN)
        (outValid && !outReady) |=> (outValid && $stable(masterResult) && $stable(slaveResult)))
        else begin
            $error("Output changed while the consumer stalled");
            failCount++;
        end

    // No multiplier exists in the slave lane
    noSlaveMul: assert property (@(posedge clk) disable iff (!rstN)
        (inValid && inReady && slaveSlot.valid) |-> (slaveSlot.op != opMul))
        else begin
            $error("Multiply accepted in the slave slot");
            failCount++;
        end

endmodule

bind dualIssueExec dualIssueExec_checker dualIssueExec_checker_inst (
    .clk          (clk),
    .rstN         (rstN),
    .inValid      (inValid),
    .inReady      (inReady),
    .outValid     (outValid),
    .outReady     (outReady),
    .slaveSlot    (slaveSlot),
    .masterResult (masterResult),
    .slaveResult  (slaveResult)
);

// ==== dv/dualIssueExec_tb.sv ====
`timescale 1ns/1ps
`include "exec_consts.svh"

module dualIssueExec_tb;
    import exec_pkg::*;

    localparam int     NumTests   = 6;
    localparam int     CycleLimit = NumTests * (`MUL_CYCLES + 10) + 200;
    localparam resultT NoResult   = '0;

    logic   clk;
    logic   rstN;
    logic   inValid;
    logic   inReady;
    logic   outValid;
    logic   outReady;
    slotT   masterSlot;
    slotT   slaveSlot;
    resultT masterResult;
    resultT slaveResult;

    int     errorCount = 0;
    int     cycleCount = 0;
    integer seed       = 32'heb;

    dualIssueExec dualIssueExec_inst (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .masterSlot   (masterSlot),
        .slaveSlot    (slaveSlot),
        .outReady     (outReady),
        .inReady      (inReady),
        .outValid     (outValid),
        .masterResult (masterResult),
        .slaveResult  (slaveResult)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
            $display("Test failed");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [`DATA_WIDTH-1:0] refAlu(input aluOpE op,
            input logic [`DATA_WIDTH-1:0] a, input logic [`DATA_WIDTH-1:0] b);
        case (op)
            opAdd:   return a + b;
            opSub:   return a - b;
            opAnd:   return a & b;
            opOr:    return a | b;
            opXor:   return a ^ b;
            opSlt:   return ($signed(a) < $signed(b)) ? `DATA_WIDTH'(1) : '0;
            opSll:   return a << b[4:0];
            default: return a * b; // Low half of the product
        endcase
    endfunction

    function automatic slotT makeSlot(input aluOpE op, input int srcA, input int srcB,
            input int dest, input logic writes);
        slotT s;
        s.valid  = 1'b1;
        s.op     = op;
        s.srcA   = srcA[`REG_ADDR_WIDTH-1:0];
        s.srcB   = srcB[`REG_ADDR_WIDTH-1:0];
        s.dest   = dest[`REG_ADDR_WIDTH-1:0];
        s.writes = writes;
        s.aValue = $random(seed);
        s.bValue = $random(seed);
        return s;
    endfunction

    function automatic resultT expectedResult(input slotT s);
        resultT r;
        r.valid = 1'b1;
        r.dest  = s.dest;
        r.value = refAlu(s.op, s.aValue, s.bValue);
        return r;
    endfunction

    task automatic compareResult(input string what, input resultT got, input resultT exp);
        logic bad;
        bad = exp.valid ? (got !== exp) : (got.valid !== 1'b0); // Empty lane only needs valid low
        if (bad) begin
            errorCount++;
            $display("Fail at %0t: %s got v=%0b d=%0d %h, expected v=%0b d=%0d %h", $time,
                     what, got.valid, got.dest, got.value, exp.valid, exp.dest, exp.value);
        end
    endtask

    task automatic compareValid(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errorCount++;
            $display("Fail at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // Returns 2 ns after the edge that accepted the pair
    task automatic sendPair(input slotT m, input slotT s);
        masterSlot = m;
        slaveSlot  = s;
        inValid    = 1'b1;
        @(negedge clk);
        while (!inReady) @(negedge clk);
        @(posedge clk);
        #2;
        inValid = 1'b0;
    endtask

    task automatic waitResult(output resultT gotM, output resultT gotS);
        outReady = 1'b1;
        while (!outValid) @(negedge clk);
        gotM = masterResult;
        gotS = slaveResult;
        @(posedge clk);
        #2;
        outReady = 1'b0;
    endtask

    task automatic issueAndCheck(input string what, input slotT m, input slotT s);
        resultT gotM;
        resultT gotS;
        sendPair(m, s);
        compareValid({what, " outValid after accept"}, outValid, 1'b1);
        waitResult(gotM, gotS);
        compareResult({what, " master"}, gotM, expectedResult(m));
        compareResult({what, " slave"}, gotS, s.valid ? expectedResult(s) : NoResult);
        compareValid({what, " outValid after transfer"}, outValid, 1'b0);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic dualIssueAllOps();
        int   round;
        int   i;
        slotT m;
        slotT s;
        for (round = 0; round < 2; round++) begin
            for (i = 0; i < 7; i++) begin
                m = makeSlot(aluOpE'(i), 10, 11, i + 1, 1'b1);
                s = makeSlot(aluOpE'((i + 3) % 7), 20, 21, i + 12, 1'b1); // No overlap with m
                issueAndCheck("dual", m, s);
            end
        end
    endtask

    task automatic loneMaster();
        slotT m;
        slotT s;
        m = makeSlot(opSub, 3, 4, 9, 1'b1);
        s = makeSlot(opAdd, 9, 9, 10, 1'b1);
        s.valid = 1'b0; // Absent slave must not split even on a matching index
        issueAndCheck("lone", m, s);
    endtask

    task automatic splitCase(input logic onA, input logic onB, input aluOpE sOp);
        slotT   m;
        slotT   s;
        slotT   fwd;
        resultT gotM;
        resultT gotS;
        m   = makeSlot(opXor, 1, 2, 6, 1'b1);
        s   = makeSlot(sOp, onA ? 6 : 7, onB ? 6 : 8, 13, 1'b1);
        fwd = s;
        if (onA) fwd.aValue = refAlu(m.op, m.aValue, m.bValue);
        if (onB) fwd.bValue = refAlu(m.op, m.aValue, m.bValue);
        sendPair(m, s);
        compareValid("split master outValid", outValid, 1'b1);
        waitResult(gotM, gotS);
        compareResult("split master", gotM, expectedResult(m));
        compareResult("split slave held back", gotS, NoResult);
        compareValid("split slave outValid", outValid, 1'b1); // One cycle after master leaves
        waitResult(gotM, gotS);
        compareResult("master after split", gotM, NoResult);
        compareResult("forwarded slave", gotS, expectedResult(fwd));
        compareValid("outValid after split", outValid, 1'b0);
    endtask

    task automatic dependentSplits();
        splitCase(1'b1, 1'b0, opSub);
        splitCase(1'b0, 1'b1, opSll);
        splitCase(1'b1, 1'b1, opAdd);
    endtask

    task automatic noSplitCases();
        issueAndCheck("dest zero", makeSlot(opOr, 1, 2, 0, 1'b1), makeSlot(opAnd, 0, 0, 14, 1'b1));
        issueAndCheck("no write", makeSlot(opAdd, 1, 2, 9, 1'b0), makeSlot(opSub, 9, 9, 15, 1'b1));
    endtask

    task automatic masterMultiply();
        int     k;
        slotT   m;
        slotT   s;
        resultT gotM;
        resultT gotS;
        for (k = 0; k < 2; k++) begin
            m = makeSlot(opMul, 3, 4, 17, 1'b1);
            s = makeSlot(opSlt, 5, 6, 18, 1'b1);
            sendPair(m, s);
            compareValid("outValid during multiply", outValid, 1'b0);
            repeat (`MUL_CYCLES - 1) begin
                @(posedge clk);
                #2;
                compareValid("outValid during multiply", outValid, 1'b0);
            end
            @(posedge clk);
            #2;
            compareValid("outValid at multiply end", outValid, 1'b1);
            waitResult(gotM, gotS);
            compareResult("multiply master", gotM, expectedResult(m));
            compareResult("multiply slave", gotS, expectedResult(s));
            compareValid("outValid after multiply", outValid, 1'b0);
        end
    endtask

    task automatic outputStall();
        slotT   firstM;
        slotT   firstS;
        slotT   nextM;
        slotT   nextS;
        resultT gotM;
        resultT gotS;
        firstM = makeSlot(opAnd, 1, 2, 21, 1'b1);
        firstS = makeSlot(opOr, 3, 4, 22, 1'b1);
        nextM  = makeSlot(opSub, 5, 6, 23, 1'b1);
        nextS  = makeSlot(opXor, 7, 8, 24, 1'b1);
        sendPair(firstM, firstS);
        masterSlot = nextM; // Second pair waits behind the stalled output
        slaveSlot  = nextS;
        inValid    = 1'b1;
        repeat (5) begin
            @(negedge clk);
            compareValid("inReady under back-pressure", inReady, 1'b0);
            compareValid("outValid under back-pressure", outValid, 1'b1);
            compareResult("stalled master", masterResult, expectedResult(firstM));
            compareResult("stalled slave", slaveResult, expectedResult(firstS));
        end
        @(posedge clk);
        #2;
        outReady = 1'b1;
        @(negedge clk);
        compareValid("inReady on release", inReady, 1'b1);
        @(posedge clk);
        #2;
        inValid  = 1'b0;
        outReady = 1'b0;
        compareValid("outValid for second pair", outValid, 1'b1);
        waitResult(gotM, gotS);
        compareResult("second master", gotM, expectedResult(nextM));
        compareResult("second slave", gotS, expectedResult(nextS));
        compareValid("outValid after second pair", outValid, 1'b0);
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        inValid    = 1'b0;
        outReady   = 1'b0;
        masterSlot = '0;
        slaveSlot  = '0;
        repeat (3) @(posedge clk);
        #2;
        rstN = 1'b1;
        @(negedge clk);
        compareValid("inReady right after reset", inReady, 1'b0);
        compareValid("outValid right after reset", outValid, 1'b0);
        @(posedge clk);
        #2;
        compareValid("inReady once idle", inReady, 1'b1);

        dualIssueAllOps();
        loneMaster();
        dependentSplits();
        noSplitCases();
        masterMultiply();
        outputStall();

        $display("Summary: %0d check errors, %0d assertion failures", errorCount,
                 dualIssueExec_inst.dualIssueExec_checker_inst.failCount);
        if ((errorCount == 0) && (dualIssueExec_inst.dualIssueExec_checker_inst.failCount == 0))
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+logic
logic/exec_pkg.sv
logic/laneBus_if.sv
logic/issueRegister.sv
logic/issueControl.sv
logic/mulCycleCounter.sv
logic/laneAlu.sv
logic/dualIssueExec.sv
dv/dualIssueExec_checker.sv
dv/dualIssueExec_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the dualIssueExec testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module dualIssueExec_tb -f list.f \
    --Mdir obj_dir -o dualIssueExec_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

# A raised error limit lets assertion failures reach the final summary
./obj_dir/dualIssueExec_sim +verilator+error+limit+100 > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1
